// File: source/idctTypesPkg.sv
//--------------------------------------------------------------------
// iDCT data types
// Sample words, 8x8 block containers and the two-word beat formats
// passed between the row pass, transpose buffer and column pass
//--------------------------------------------------------------------
package idctTypesPkg;

   // Sample words at each stage
   typedef logic signed [15:0] coefWord;
   typedef logic signed [15:0] rowWord;
   typedef logic signed [8:0]  pixelWord;

   // Line of a block (page) and beat within a line
   typedef logic [2:0] lineIndex;
   typedef logic [1:0] beatIndex;

   // Eight words of one line for a dot product
   typedef logic [7:0][15:0] coefVector;

   // Full blocks indexed as word[row * 8 + column]
   typedef struct packed {
      coefWord [63:0] word;
   } coefBlock;

   typedef struct packed {
      rowWord [63:0] word;
   } rowBlock;

   // Two results of one line per beat
   typedef struct packed {
      lineIndex page;
      beatIndex count;
      rowWord   data0;
      rowWord   data1;
   } rowBeat;

   typedef struct packed {
      lineIndex page;
      beatIndex count;
      pixelWord data0;
      pixelWord data1;
   } pixelBeat;

endpackage

// File: source/idctConstPkg.sv
//--------------------------------------------------------------------
// iDCT arithmetic constants
// Block geometry, fixed point cosine table and rounding bias
//--------------------------------------------------------------------
package idctConstPkg;

   localparam int BlockDim      = 8;
   localparam int BeatsPerLine  = BlockDim / 2;
   localparam int BeatsPerBlock = BlockDim * BeatsPerLine;

   // Table scale is 2^11, results round half up before the shift
   localparam int CosFracBits = 11;
   localparam int RoundBias   = 1 << (CosFracBits - 1);

   //-----------------------------------------------------------------
   // CosTable[k][n] = round(2048 * ck/2 * cos((2n+1) k pi / 16))
   // c0 = 1/sqrt(2), other ck = 1
   //-----------------------------------------------------------------
   localparam logic signed [11:0] CosTable [0:7][0:7] = '{
      '{  724,   724,   724,   724,   724,   724,   724,   724 },
      '{ 1004,   851,   569,   200,  -200,  -569,  -851, -1004 },
      '{  946,   392,  -392,  -946,  -946,  -392,   392,   946 },
      '{  851,  -200, -1004,  -569,   569,  1004,   200,  -851 },
      '{  724,  -724,  -724,   724,   724,  -724,  -724,   724 },
      '{  569, -1004,   200,   851,  -851,  -200,  1004,  -569 },
      '{  392,  -946,   946,  -392,  -392,   946,  -946,   392 },
      '{  200,  -569,   851, -1004,  1004,  -851,   569,  -200 }
   };

endpackage

// File: source/idctDotProduct.sv
//--------------------------------------------------------------------
// iDCT dot product
// One 8-tap cosine sum for output index line, rounded, scaled down
// by the table fraction and saturated to OutWidth
//--------------------------------------------------------------------
module idctDotProduct
   import idctTypesPkg::*;
   import idctConstPkg::*;
#(
   parameter int OutWidth = 16
) (
   input  coefVector                  coefs,
   input  lineIndex                   line,
   output logic signed [OutWidth-1:0] result
);

   // Eight 16x12 products fit easily
   localparam int AccWidth = 32;
   localparam logic signed [AccWidth-1:0] MaxOut = (2 ** (OutWidth - 1)) - 1;
   localparam logic signed [AccWidth-1:0] MinOut = -(2 ** (OutWidth - 1));

   logic signed [AccWidth-1:0] acc;
   logic signed [AccWidth-1:0] scaled;

   always_comb begin
      acc = '0;
      for (int k = 0; k < BlockDim; k++) begin
         acc = acc + $signed(coefs[k]) * CosTable[k][line];
      end

      scaled = (acc + RoundBias) >>> CosFracBits;

      // Clamp to the signed output range
      if (scaled > MaxOut) begin
         result = MaxOut[OutWidth-1:0];
      end else if (scaled < MinOut) begin
         result = MinOut[OutWidth-1:0];
      end else begin
         result = scaled[OutWidth-1:0];
      end
   end

endmodule

// File: source/idctRowPass.sv
//--------------------------------------------------------------------
// iDCT row pass
// Captures a coefficient block, waits for a free buffer bank, then
// emits the eight row transforms as 32 beats of two results
//--------------------------------------------------------------------
module idctRowPass
   import idctTypesPkg::*;
   import idctConstPkg::*;
#(
   parameter int OutWidth = 16
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     dataInEnable,
   input  coefBlock dataIn,
   input  logic     bufIdle,
   output logic     dataInIdle,
   output logic     dataInRelease,
   output logic     rowEnable,
   output rowBeat   rowOut
);

   localparam logic [4:0] LastBeat = 5'(BeatsPerBlock - 1);

   typedef enum logic [1:0] {
      Idle,
      Wait,
      Run
   } rowPassState;

   rowPassState                state;
   coefBlock                   blockReg;
   lineIndex                   page;
   beatIndex                   count;
   coefVector                  rowCoefs;
   logic signed [OutWidth-1:0] result0;
   logic signed [OutWidth-1:0] result1;
   logic                       capture;
   logic                       fire;
   logic                       lastOut;

   assign dataInIdle = (state == Idle);
   assign capture    = dataInEnable && dataInIdle;

   // Final beat of the block is on the bus now
   assign lastOut = rowEnable && ({rowOut.page, rowOut.count} == LastBeat);

   // First beat is computed in the cycle the buffer is seen free
   assign fire = ((state == Wait) && bufIdle) || ((state == Run) && !lastOut);

   assign rowCoefs = blockReg.word[page * BlockDim +: BlockDim];

   //-----------------------------------------------------------------
   // Even and odd outputs of the current row
   //-----------------------------------------------------------------
   idctDotProduct #(
      .OutWidth (OutWidth)
   ) dotEven (
      .coefs  (rowCoefs),
      .line   ({count, 1'b0}),
      .result (result0)
   );

   idctDotProduct #(
      .OutWidth (OutWidth)
   ) dotOdd (
      .coefs  (rowCoefs),
      .line   ({count, 1'b1}),
      .result (result1)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         state         <= Idle;
         page          <= '0;
         count         <= '0;
         rowEnable     <= 1'b0;
         dataInRelease <= 1'b0;
      end else begin
         rowEnable     <= fire;
         dataInRelease <= lastOut;
         if (fire) begin
            count <= count + 1'b1;
            if (count == beatIndex'(BeatsPerLine - 1)) begin
               page <= page + 1'b1;
            end
         end
         case (state)
            Idle: begin
               if (capture) begin
                  state <= Wait;
               end
            end
            Wait: begin
               if (bufIdle) begin
                  state <= Run;
               end
            end
            Run: begin
               if (lastOut) begin
                  state <= Idle;
               end
            end
            default: begin
               state <= Idle;
            end
         endcase
      end
   end

   // Block and beat payload
   always_ff @(posedge clk) begin
      if (capture) begin
         blockReg <= dataIn;
      end
      if (fire) begin
         rowOut.page  <= page;
         rowOut.count <= count;
         rowOut.data0 <= rowWord'(result0);
         rowOut.data1 <= rowWord'(result1);
      end
   end

endmodule

// File: source/idctTransposeBuffer.sv
//--------------------------------------------------------------------
// iDCT transpose buffer
// Two banks written by the row pass in transposed order, so each
// line of the read bank holds one image column for the column pass
//--------------------------------------------------------------------
module idctTransposeBuffer
   import idctTypesPkg::*;
   import idctConstPkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    rowEnable,
   input  rowBeat  rowIn,
   input  logic    bankRelease,
   output logic    bufIdle,
   output logic    bankFull,
   output rowBlock bankData
);

   localparam logic [4:0] LastBeat = 5'(BeatsPerBlock - 1);

   rowBlock    bankMem [0:1];
   logic       wrPtr;
   logic       rdPtr;
   logic [1:0] full;
   logic       lastIn;
   logic [5:0] addr0;
   logic [5:0] addr1;

   assign bufIdle  = !full[wrPtr];
   assign bankFull = full[rdPtr];
   assign bankData = bankMem[rdPtr];

   assign lastIn = rowEnable && ({rowIn.page, rowIn.count} == LastBeat);

   // Result n of row page lands at line n, position page
   assign addr0 = {rowIn.count, 1'b0, rowIn.page};
   assign addr1 = {rowIn.count, 1'b1, rowIn.page};

   //-----------------------------------------------------------------
   // Bank storage
   //-----------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rowEnable) begin
         bankMem[wrPtr].word[addr0] <= rowIn.data0;
         bankMem[wrPtr].word[addr1] <= rowIn.data1;
      end
   end

   //-----------------------------------------------------------------
   // Bank pointers and full flags
   //-----------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         wrPtr <= 1'b0;
         rdPtr <= 1'b0;
         full  <= '0;
      end else begin
         // Write bank is never full here, read bank always is
         if (lastIn) begin
            full[wrPtr] <= 1'b1;
            wrPtr       <= !wrPtr;
         end
         if (bankRelease) begin
            full[rdPtr] <= 1'b0;
            rdPtr       <= !rdPtr;
         end
      end
   end

endmodule

// File: source/idctColumnPass.sv
//--------------------------------------------------------------------
// iDCT column pass
// Transforms the lines of a full buffer bank into pixel beats and
// hands the bank back after the last beat
//--------------------------------------------------------------------
module idctColumnPass
   import idctTypesPkg::*;
   import idctConstPkg::*;
#(
   parameter int OutWidth = 9
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     bankFull,
   input  rowBlock  bankData,
   output logic     bankRelease,
   output logic     dataOutEnable,
   output pixelBeat dataOut
);

   localparam logic [4:0] LastBeat = 5'(BeatsPerBlock - 1);

   typedef enum logic [1:0] {
      Idle,
      Run,
      Done
   } colPassState;

   colPassState                state;
   lineIndex                   page;
   beatIndex                   count;
   coefVector                  lineCoefs;
   logic signed [OutWidth-1:0] result0;
   logic signed [OutWidth-1:0] result1;
   logic                       fire;
   logic                       lastOut;

   assign lastOut     = dataOutEnable && ({dataOut.page, dataOut.count} == LastBeat);
   assign fire        = ((state == Idle) && bankFull) || ((state == Run) && !lastOut);
   assign bankRelease = (state == Done);

   // Line page of the read bank is image column page
   assign lineCoefs = bankData.word[page * BlockDim +: BlockDim];

   idctDotProduct #(
      .OutWidth (OutWidth)
   ) dotEven (
      .coefs  (lineCoefs),
      .line   ({count, 1'b0}),
      .result (result0)
   );

   idctDotProduct #(
      .OutWidth (OutWidth)
   ) dotOdd (
      .coefs  (lineCoefs),
      .line   ({count, 1'b1}),
      .result (result1)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         state         <= Idle;
         page          <= '0;
         count         <= '0;
         dataOutEnable <= 1'b0;
      end else begin
         dataOutEnable <= fire;
         if (fire) begin
            count <= count + 1'b1;
            if (count == beatIndex'(BeatsPerLine - 1)) begin
               page <= page + 1'b1;
            end
         end
         case (state)
            Idle: begin
               if (bankFull) begin
                  state <= Run;
               end
            end
            Run: begin
               if (lastOut) begin
                  state <= Done;
               end
            end
            // Buffer flags settle while here
            default: begin
               state <= Idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         dataOut.page  <= page;
         dataOut.count <= count;
         dataOut.data0 <= pixelWord'(result0);
         dataOut.data1 <= pixelWord'(result1);
      end
   end

endmodule

// File: source/jpegIdct.sv
//--------------------------------------------------------------------
// JPEG 8x8 inverse DCT
// Row pass, two-bank transpose buffer and column pass in a pipeline
//--------------------------------------------------------------------
module jpegIdct
   import idctTypesPkg::*;
#(
   parameter int RowWidth   = $bits(rowWord),
   parameter int PixelWidth = $bits(pixelWord)
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     dataInEnable,
   input  coefBlock dataIn,
   output logic     dataInIdle,
   output logic     dataInRelease,
   output logic     dataOutEnable,
   output pixelBeat dataOut
);

   logic    rowEnable;
   rowBeat  rowData;
   logic    bufIdle;
   logic    bankFull;
   rowBlock bankData;
   logic    bankRelease;

   idctRowPass #(
      .OutWidth (RowWidth)
   ) rowPass (
      .clk           (clk),
      .reset         (reset),
      .dataInEnable  (dataInEnable),
      .dataIn        (dataIn),
      .bufIdle       (bufIdle),
      .dataInIdle    (dataInIdle),
      .dataInRelease (dataInRelease),
      .rowEnable     (rowEnable),
      .rowOut        (rowData)
   );

   idctTransposeBuffer transposeBuffer (
      .clk         (clk),
      .reset       (reset),
      .rowEnable   (rowEnable),
      .rowIn       (rowData),
      .bankRelease (bankRelease),
      .bufIdle     (bufIdle),
      .bankFull    (bankFull),
      .bankData    (bankData)
   );

   idctColumnPass #(
      .OutWidth (PixelWidth)
   ) columnPass (
      .clk           (clk),
      .reset         (reset),
      .bankFull      (bankFull),
      .bankData      (bankData),
      .bankRelease   (bankRelease),
      .dataOutEnable (dataOutEnable),
      .dataOut       (dataOut)
   );

endmodule

// File: verif/idctRefModel.svh
//--------------------------------------------------------------------
// iDCT reference model
// Separable 2-D transform, rows then columns, and the queue of
// pixel beats expected from the DUT
//--------------------------------------------------------------------
`ifndef IDCT_REF_MODEL_SVH
`define IDCT_REF_MODEL_SVH

pixelBeat expectedBeats [$];

// Add half an LSB, then drop the 11 fraction bits
function automatic int roundShift(input int acc);
   return (acc + 1024) >>> 11;
endfunction

function automatic int clampTo(input int value, input int width);
   int hi;
   int lo;
   hi = (1 << (width - 1)) - 1;
   lo = -(1 << (width - 1));
   if (value > hi) begin
      return hi;
   end else if (value < lo) begin
      return lo;
   end
   return value;
endfunction

//--------------------------------------------------------------------
// Full block to 32 beats in column order
//--------------------------------------------------------------------
function automatic void pushBlockBeats(input coefBlock blk);
   int       rowRes [0:7][0:7];
   int       pix [0:7][0:7];
   int       acc;
   pixelBeat beat;
   for (int i = 0; i < BlockDim; i++) begin
      for (int n = 0; n < BlockDim; n++) begin
         acc = 0;
         for (int k = 0; k < BlockDim; k++) begin
            acc = acc + int'($signed(blk.word[i * BlockDim + k])) * int'(CosTable[k][n]);
         end
         rowRes[i][n] = clampTo(roundShift(acc), 16);
      end
   end
   // Column j of the row results gives image column j
   for (int j = 0; j < BlockDim; j++) begin
      for (int n = 0; n < BlockDim; n++) begin
         acc = 0;
         for (int k = 0; k < BlockDim; k++) begin
            acc = acc + rowRes[k][j] * int'(CosTable[k][n]);
         end
         pix[n][j] = clampTo(roundShift(acc), 9);
      end
   end
   for (int j = 0; j < BlockDim; j++) begin
      for (int c = 0; c < BeatsPerLine; c++) begin
         beat.page  = lineIndex'(j);
         beat.count = beatIndex'(c);
         beat.data0 = pixelWord'(pix[2 * c][j]);
         beat.data1 = pixelWord'(pix[2 * c + 1][j]);
         expectedBeats.push_back(beat);
      end
   end
endfunction

`endif

// File: verif/tbJpegIdct.sv
//--------------------------------------------------------------------
// Testbench for the JPEG 8x8 inverse DCT
// Random blocks from a fixed seed, checked beat by beat against
// the reference model, with input strobe and release tracking
//--------------------------------------------------------------------
module tbJpegIdct
   import idctTypesPkg::*;
   import idctConstPkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NumBlocks     = 20;
   localparam int TimeoutCycles = NumBlocks * 100 + 1000;
   localparam int DrainCycles   = 50;
   localparam int DcOnly        = 0;
   localparam int SmallCoefs    = 1;
   localparam int LargeCoefs    = 2;

   logic     clk;
   logic     reset;
   logic     dataInEnable;
   coefBlock dataIn;
   logic     dataInIdle;
   logic     dataInRelease;
   logic     dataOutEnable;
   pixelBeat dataOut;

   integer   seed = 32'hb1e3;
   int       cycleCount = 0;
   logic     inRow = 1'b0;
   pixelBeat expBeat;
   coefBlock nextBlock;
   int       kind;
   int       gap;
   logic     holdEnable;

   `include "idctRefModel.svh"

   jpegIdct dut_i (
      .clk           (clk),
      .reset         (reset),
      .dataInEnable  (dataInEnable),
      .dataIn        (dataIn),
      .dataInIdle    (dataInIdle),
      .dataInRelease (dataInRelease),
      .dataOutEnable (dataOutEnable),
      .dataOut       (dataOut)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   //-----------------------------------------------------------------
   // Failure handling and compare tasks
   //-----------------------------------------------------------------
   task automatic abortRun();
      $display("TB FAILED");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic checkBit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("[ERROR] %0t %s expected %b got %b", $time, name, expected, actual);
         abortRun();
      end
   endtask

   task automatic checkBeat(input string name, input pixelBeat expected, input pixelBeat actual);
      if (actual !== expected) begin
         $display({"[ERROR] %0t %s expected page %0d count %0d data %0d %0d",
                   " got page %0d count %0d data %0d %0d"},
                  $time, name, expected.page, expected.count, expected.data0,
                  expected.data1, actual.page, actual.count, actual.data0, actual.data1);
         abortRun();
      end
   endtask

   task automatic makeBlock(input int blockKind, output coefBlock blk);
      int value;
      blk = '0;
      if (blockKind == DcOnly) begin
         value = $random(seed) % 2041;
         blk.word[0] = coefWord'(value);
      end else begin
         for (int i = 0; i < BlockDim * BlockDim; i++) begin
            value = $random(seed);
            if (blockKind == SmallCoefs) begin
               value = value % 513;
            end
            blk.word[i] = coefWord'(value);
         end
      end
   endtask

   // Starts right after a rising edge and returns after the capture edge
   task automatic driveBlock(input coefBlock blk, input logic hold);
      dataInEnable <= 1'b1;
      dataIn       <= blk;
      do begin
         @(negedge clk);
      end while (!dataInIdle);
      @(posedge clk);
      if (!hold) begin
         dataInEnable <= 1'b0;
      end
   endtask

   //-----------------------------------------------------------------
   // Monitor sampled on the falling edge
   //-----------------------------------------------------------------
   always @(negedge clk) begin
      if (!reset) begin
         if (dataInRelease) begin
            checkBit("dataInRelease", inRow, dataInRelease);
            inRow = 1'b0;
         end
         checkBit("dataInIdle", !inRow, dataInIdle);
         // Block is taken at the next rising edge
         if (dataInEnable && dataInIdle) begin
            pushBlockBeats(dataIn);
            inRow = 1'b1;
         end
         if (dataOutEnable) begin
            if (expectedBeats.size() == 0) begin
               $display("Pixel beat at %0t arrived with no block outstanding", $time);
               abortRun();
            end else begin
               expBeat = expectedBeats.pop_front();
               checkBeat("dataOut", expBeat, dataOut);
            end
         end
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= TimeoutCycles) begin
         $display("Run timed out after %0d cycles, %0d beats still expected",
                  cycleCount, expectedBeats.size());
         abortRun();
      end
   end

   //-----------------------------------------------------------------
   // Stimulus
   //-----------------------------------------------------------------
   initial begin
      reset        = 1'b1;
      dataInEnable = 1'b0;
      dataIn       = '0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      checkBit("dataInIdle", 1'b1, dataInIdle);
      checkBit("dataInRelease", 1'b0, dataInRelease);
      checkBit("dataOutEnable", 1'b0, dataOutEnable);
      @(posedge clk);

      // DC block, small blocks, saturating blocks, then back to back
      for (int blockNum = 0; blockNum < NumBlocks; blockNum++) begin
         if (blockNum == 0) begin
            kind = DcOnly;
         end else if (blockNum >= 8 && blockNum < 12) begin
            kind = LargeCoefs;
         end else begin
            kind = SmallCoefs;
         end
         holdEnable = (blockNum >= 12) && (blockNum < NumBlocks - 1);
         makeBlock(kind, nextBlock);
         driveBlock(nextBlock, holdEnable);
         if (!holdEnable) begin
            gap = $random(seed) & 3;
            repeat (gap) @(posedge clk);
         end
      end

      while (expectedBeats.size() != 0 || inRow) begin
         @(posedge clk);
      end
      // Stray beats or releases would still show up here
      repeat (DrainCycles) @(posedge clk);

      $display("TB PASSED");
      $finish;
   end

endmodule

// File: jpegIdct.f
+incdir+verif
source/idctTypesPkg.sv
source/idctConstPkg.sv
source/idctDotProduct.sv
source/idctRowPass.sv
source/idctTransposeBuffer.sv
source/idctColumnPass.sv
source/jpegIdct.sv
verif/tbJpegIdct.sv

// File: Bender.yml
package:
  name: jpeg_idct

sources:
  # Packages first, then the pipeline stages and the top level
  - source/idctTypesPkg.sv
  - source/idctConstPkg.sv
  - source/idctDotProduct.sv
  - source/idctRowPass.sv
  - source/idctTransposeBuffer.sv
  - source/idctColumnPass.sv
  - source/jpegIdct.sv

  # Testbench with its reference model header
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tbJpegIdct.sv
